// File: Makefile
VERILATOR ?= verilator
TOP       ?= l1_cache_tb
FILELIST  ?= l1_cache.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TEST PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation passes only if its output holds the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/cache_ctrl.sv
module cache_ctrl (
	input  logic clk,
	input  logic rst_n_i,
	input  logic req_i,
	input  logic req_we_i,
	input  logic hit_i,
	input  logic dirty_i,
	input  logic mem_done_i,
	output logic busy_o,
	output logic wb_start_o,
	output logic fill_start_o,
	output logic fill_o,
	output logic wr_word_o,
	output logic done_o
);

	logic [cache_pkg::ST_W-1:0] state_q;
	logic [cache_pkg::ST_W-1:0] state_d;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q <= cache_pkg::ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d      = state_q;
		wb_start_o   = 1'b0;
		fill_start_o = 1'b0;
		fill_o       = 1'b0;
		wr_word_o    = 1'b0;
		done_o       = 1'b0;
		case (state_q)
			cache_pkg::ST_IDLE: begin
				if (req_i) begin
					state_d = cache_pkg::ST_LOOKUP;
				end
			end
			cache_pkg::ST_LOOKUP: begin
				if (hit_i) begin
					// write hit merges the word on this edge
					wr_word_o = req_we_i;
					done_o    = 1'b1;
					state_d   = cache_pkg::ST_RESPOND;
				end else if (dirty_i) begin
					wb_start_o = 1'b1;
					state_d    = cache_pkg::ST_WRITE_BACK;
				end else begin
					fill_start_o = 1'b1;
					state_d      = cache_pkg::ST_REFILL;
				end
			end
			cache_pkg::ST_WRITE_BACK: begin
				// victim is out, fetch the new line
				if (mem_done_i) begin
					fill_start_o = 1'b1;
					state_d      = cache_pkg::ST_REFILL;
				end
			end
			cache_pkg::ST_REFILL: begin
				// install the line, then look up again
				if (mem_done_i) begin
					fill_o  = 1'b1;
					state_d = cache_pkg::ST_LOOKUP;
				end
			end
			cache_pkg::ST_RESPOND: begin
				state_d = cache_pkg::ST_IDLE;
			end
			default: begin
				state_d = cache_pkg::ST_IDLE;
			end
		endcase
	end

	// respond is the ack cycle, the cpu may strobe again after it
	assign busy_o = req_i
		|| (state_q == cache_pkg::ST_LOOKUP)
		|| (state_q == cache_pkg::ST_WRITE_BACK)
		|| (state_q == cache_pkg::ST_REFILL);

endmodule

// File: design/cache_pkg.sv
package cache_pkg;

	// cpu side geometry
	localparam int ADDR_W         = 32;
	localparam int WORD_W         = 32;
	localparam int TAG_W          = 22;
	localparam int INDEX_W        = 5;
	localparam int WSEL_W         = 3;
	localparam int BYTE_W         = ADDR_W - TAG_W - INDEX_W - WSEL_W;
	localparam int OFFSET_W       = WSEL_W + BYTE_W;
	localparam int NUM_LINES      = 32;
	localparam int WORDS_PER_LINE = 8;

	// controller state codes
	localparam int          ST_W          = 3;
	localparam logic [2:0]  ST_IDLE       = 3'd0;
	localparam logic [2:0]  ST_LOOKUP     = 3'd1;
	localparam logic [2:0]  ST_WRITE_BACK = 3'd2;
	localparam logic [2:0]  ST_REFILL     = 3'd3;
	localparam logic [2:0]  ST_RESPOND    = 3'd4;

	// one cpu address, seen as lookup fields or as a line number
	typedef union packed {
		struct packed {
			logic [TAG_W-1:0]   tag;
			logic [INDEX_W-1:0] index;
			logic [WSEL_W-1:0]  wsel;
			logic [BYTE_W-1:0]  byte_off;
		} f;
		struct packed {
			logic [TAG_W+INDEX_W-1:0] line_num;
			logic [OFFSET_W-1:0]      line_off;
		} l;
	} cpu_addr_u;

endpackage

// File: design/cpu_port.sv
module cpu_port (
	input  logic                             clk,
	input  logic                             rst_n_i,
	input  logic [cache_pkg::ADDR_W-1:0]     cache_addr_i,
	input  logic                             cache_cs_i,
	input  logic                             cache_we_i,
	input  logic [cache_pkg::WORD_W-1:0]     cache_data_i,
	input  logic                             busy_i,
	input  logic                             done_i,
	input  mem_pkg::line_t                   line_i,
	output logic                             req_o,
	output cache_pkg::cpu_addr_u             req_addr_o,
	output logic                             req_we_o,
	output logic [cache_pkg::WORD_W-1:0]     req_wdata_o,
	output logic                             cache_ack_o,
	output logic [cache_pkg::WORD_W-1:0]     cache_data_o
);

	logic accept;

	// strobes seen while a request is in flight are dropped
	assign accept = cache_cs_i && !busy_i;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			req_o       <= 1'b0;
			cache_ack_o <= 1'b0;
		end else begin
			req_o       <= accept;
			cache_ack_o <= done_i;
		end
	end

	// request payload, held until the next accepted strobe
	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr_o  <= cache_addr_i;
			req_we_o    <= cache_we_i;
			req_wdata_o <= cache_data_i;
		end
	end

	// word picked out of the hit line
	always_ff @(posedge clk) begin
		if (done_i) begin
			cache_data_o <= line_i[req_addr_o.f.wsel * cache_pkg::WORD_W +: cache_pkg::WORD_W];
		end
	end

endmodule

// File: design/dram_port.sv
module dram_port (
	input  logic                              clk,
	input  logic                              rst_n_i,
	input  logic                              wb_start_i,
	input  logic                              fill_start_i,
	input  cache_pkg::cpu_addr_u              req_addr_i,
	input  logic [cache_pkg::TAG_W-1:0]       victim_tag_i,
	input  mem_pkg::line_t                    wb_line_i,
	input  logic                              dram_ack_i,
	input  mem_pkg::line_t                    dram_data_i,
	output logic [mem_pkg::DRAM_ADDR_W-1:0]   dram_addr_o,
	output logic                              dram_cs_o,
	output logic                              dram_we_o,
	output mem_pkg::line_t                    dram_data_o,
	output logic                              mem_done_o,
	output mem_pkg::line_t                    fill_line_o
);

	logic pending_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			dram_cs_o  <= 1'b0;
			dram_we_o  <= 1'b0;
			pending_q  <= 1'b0;
			mem_done_o <= 1'b0;
		end else begin
			dram_cs_o  <= wb_start_i || fill_start_i;
			mem_done_o <= pending_q && dram_ack_i;
			if (wb_start_i || fill_start_i) begin
				pending_q <= 1'b1;
				dram_we_o <= wb_start_i;
			end else if (pending_q && dram_ack_i) begin
				pending_q <= 1'b0;
			end
		end
	end

	// line aligned addresses, write-back uses the stored tag
	always_ff @(posedge clk) begin
		if (wb_start_i) begin
			dram_addr_o <= {victim_tag_i, req_addr_i.f.index, {cache_pkg::OFFSET_W{1'b0}}};
			dram_data_o <= wb_line_i;
		end else if (fill_start_i) begin
			dram_addr_o <= {req_addr_i.l.line_num, {cache_pkg::OFFSET_W{1'b0}}};
		end
		if (pending_q && dram_ack_i && !dram_we_o) begin
			fill_line_o <= dram_data_i;
		end
	end

endmodule

// File: design/l1_cache.sv
module l1_cache (
	input  logic                              clk,
	input  logic                              rst_n_i,

	// cpu side
	input  logic [cache_pkg::ADDR_W-1:0]      cache_addr_i,
	input  logic                              cache_cs_i,
	input  logic                              cache_we_i,
	input  logic [cache_pkg::WORD_W-1:0]      cache_data_i,
	output logic                              cache_ack_o,
	output logic [cache_pkg::WORD_W-1:0]      cache_data_o,

	// dram side
	output logic [mem_pkg::DRAM_ADDR_W-1:0]   dram_addr_o,
	output logic                              dram_cs_o,
	output logic                              dram_we_o,
	input  logic                              dram_ack_i,
	input  mem_pkg::line_t                    dram_data_i,
	output mem_pkg::line_t                    dram_data_o
);

	logic                         req;
	cache_pkg::cpu_addr_u         req_addr;
	logic                         req_we;
	logic [cache_pkg::WORD_W-1:0] req_wdata;
	logic                         busy;
	logic                         done;
	logic                         wb_start;
	logic                         fill_start;
	logic                         fill;
	logic                         wr_word;
	logic                         hit;
	logic                         dirty;
	logic [cache_pkg::TAG_W-1:0]  victim_tag;
	mem_pkg::line_t               line;
	logic                         mem_done;
	mem_pkg::line_t               fill_line;

	cpu_port u_cpu_port (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.cache_addr_i (cache_addr_i),
		.cache_cs_i   (cache_cs_i),
		.cache_we_i   (cache_we_i),
		.cache_data_i (cache_data_i),
		.busy_i       (busy),
		.done_i       (done),
		.line_i       (line),
		.req_o        (req),
		.req_addr_o   (req_addr),
		.req_we_o     (req_we),
		.req_wdata_o  (req_wdata),
		.cache_ack_o  (cache_ack_o),
		.cache_data_o (cache_data_o)
	);

	cache_ctrl u_cache_ctrl (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.req_i        (req),
		.req_we_i     (req_we),
		.hit_i        (hit),
		.dirty_i      (dirty),
		.mem_done_i   (mem_done),
		.busy_o       (busy),
		.wb_start_o   (wb_start),
		.fill_start_o (fill_start),
		.fill_o       (fill),
		.wr_word_o    (wr_word),
		.done_o       (done)
	);

	line_store u_line_store (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.addr_i       (req_addr),
		.fill_i       (fill),
		.fill_line_i  (fill_line),
		.wr_word_i    (wr_word),
		.wdata_i      (req_wdata),
		.hit_o        (hit),
		.dirty_o      (dirty),
		.victim_tag_o (victim_tag),
		.line_o       (line)
	);

	dram_port u_dram_port (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.wb_start_i   (wb_start),
		.fill_start_i (fill_start),
		.req_addr_i   (req_addr),
		.victim_tag_i (victim_tag),
		.wb_line_i    (line),
		.dram_ack_i   (dram_ack_i),
		.dram_data_i  (dram_data_i),
		.dram_addr_o  (dram_addr_o),
		.dram_cs_o    (dram_cs_o),
		.dram_we_o    (dram_we_o),
		.dram_data_o  (dram_data_o),
		.mem_done_o   (mem_done),
		.fill_line_o  (fill_line)
	);

endmodule

// File: design/line_store.sv
module line_store (
	input  logic                             clk,
	input  logic                             rst_n_i,
	input  cache_pkg::cpu_addr_u             addr_i,
	input  logic                             fill_i,
	input  mem_pkg::line_t                   fill_line_i,
	input  logic                             wr_word_i,
	input  logic [cache_pkg::WORD_W-1:0]     wdata_i,
	output logic                             hit_o,
	output logic                             dirty_o,
	output logic [cache_pkg::TAG_W-1:0]      victim_tag_o,
	output mem_pkg::line_t                   line_o
);

	logic [cache_pkg::TAG_W-1:0]     tag_mem [cache_pkg::NUM_LINES];
	mem_pkg::line_t                  data_mem [cache_pkg::NUM_LINES];
	logic [cache_pkg::NUM_LINES-1:0] valid_q;
	logic [cache_pkg::NUM_LINES-1:0] dirty_q;
	logic [cache_pkg::INDEX_W-1:0]   idx;

	assign idx = addr_i.f.index;

	// combinational read of the indexed line
	assign hit_o        = valid_q[idx] && (tag_mem[idx] == addr_i.f.tag);
	assign dirty_o      = valid_q[idx] && dirty_q[idx];
	assign victim_tag_o = tag_mem[idx];
	assign line_o       = data_mem[idx];

	always_ff @(posedge clk) begin
		if (fill_i) begin
			tag_mem[idx]  <= addr_i.f.tag;
			data_mem[idx] <= fill_line_i;
		end else if (wr_word_i) begin
			data_mem[idx][addr_i.f.wsel * cache_pkg::WORD_W +: cache_pkg::WORD_W] <= wdata_i;
		end
	end

	// a refill leaves the line clean, a word write makes it dirty
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (fill_i) begin
			valid_q[idx] <= 1'b1;
			dirty_q[idx] <= 1'b0;
		end else if (wr_word_i) begin
			dirty_q[idx] <= 1'b1;
		end
	end

endmodule

// File: design/mem_pkg.sv
package mem_pkg;

	// dram bus widths
	localparam int DRAM_ADDR_W = 32;
	localparam int LINE_W      = 256;

	// one full cache line as moved over the dram bus
	typedef logic [LINE_W-1:0] line_t;

endpackage

// File: l1_cache.f
design/cache_pkg.sv
design/mem_pkg.sv
design/cpu_port.sv
design/cache_ctrl.sv
design/line_store.sv
design/dram_port.sv
design/l1_cache.sv
sim/dram_model.sv
sim/l1_cache_tb.sv

// File: sim/dram_model.sv
module dram_model #(
	parameter logic [31:0] PATTERN_KEY = 32'h5a5a_0000
) (
	input  logic                            clk,
	input  logic                            rst_n_i,
	input  logic [mem_pkg::DRAM_ADDR_W-1:0] dram_addr_i,
	input  logic                            dram_cs_i,
	input  logic                            dram_we_i,
	input  mem_pkg::line_t                  dram_data_i,
	output logic                            dram_ack_o,
	output mem_pkg::line_t                  dram_data_o,
	output int                              rd_count_o,
	output int                              wr_count_o,
	output logic [mem_pkg::DRAM_ADDR_W-1:0] last_wr_addr_o,
	output mem_pkg::line_t                  last_wr_line_o
);

	// lines written back so far, keyed by line address
	mem_pkg::line_t lines [logic [mem_pkg::DRAM_ADDR_W-1:0]];
	integer         seed = 32'hffe6_f1e2;
	int             wait_q;

	// untouched lines hold word address xor key
	function automatic mem_pkg::line_t read_line(input logic [31:0] base);
		mem_pkg::line_t l;
		if (lines.exists(base)) begin
			return lines[base];
		end
		for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
			l[w*cache_pkg::WORD_W +: cache_pkg::WORD_W] = (base + 32'(w * 4)) ^ PATTERN_KEY;
		end
		return l;
	endfunction

	initial begin
		dram_ack_o  = 1'b0;
		dram_data_o = '0;
	end

	always @(negedge clk) begin
		if (!rst_n_i) begin
			dram_ack_o <= 1'b0;
			rd_count_o <= 0;
			wr_count_o <= 0;
			wait_q     <= 0;
		end else begin
			dram_ack_o <= 1'b0;
			if (wait_q > 1) begin
				wait_q <= wait_q - 1;
			end else if (wait_q == 1) begin
				wait_q     <= 0;
				dram_ack_o <= 1'b1;
				if (dram_we_i) begin
					lines[dram_addr_i] = dram_data_i;
					last_wr_addr_o <= dram_addr_i;
					last_wr_line_o <= dram_data_i;
					wr_count_o     <= wr_count_o + 1;
				end else begin
					dram_data_o <= read_line(dram_addr_i);
					rd_count_o  <= rd_count_o + 1;
				end
			end else if (dram_cs_i) begin
				// acknowledge after one to four cycles
				wait_q <= 1 + int'($unsigned($random(seed)) % 4);
			end
		end
	end

endmodule

// File: sim/l1_cache_tb.sv
module l1_cache_tb;

	localparam logic [31:0] PATTERN_KEY = 32'h5a5a_0000;
	localparam int          TIMEOUT     = 40;

	typedef struct {
		logic        we;
		logic        extra;
		logic [31:0] addr;
		logic [31:0] wdata;
		int          exp_rd;
		int          exp_wr;
		logic [31:0] wb_addr;
	} step_t;

	logic                clk;
	logic                rst_n;
	logic [31:0]         cache_addr;
	logic                cache_cs;
	logic                cache_we;
	logic [31:0]         cache_data;
	logic                cache_ack;
	logic [31:0]         cache_rdata;
	logic [31:0]         dram_addr;
	logic                dram_cs;
	logic                dram_we;
	logic                dram_ack;
	mem_pkg::line_t      dram_rdata;
	mem_pkg::line_t      dram_wdata;
	int                  rd_count;
	int                  wr_count;
	logic [31:0]         last_wr_addr;
	mem_pkg::line_t      last_wr_line;
	step_t               steps [$];
	logic [31:0]         ref_mem [logic [31:0]];
	int                  errors;
	int                  failed_steps;
	int                  ack_count;

	l1_cache u_l1_cache (
		.clk          (clk),
		.rst_n_i      (rst_n),
		.cache_addr_i (cache_addr),
		.cache_cs_i   (cache_cs),
		.cache_we_i   (cache_we),
		.cache_data_i (cache_data),
		.cache_ack_o  (cache_ack),
		.cache_data_o (cache_rdata),
		.dram_addr_o  (dram_addr),
		.dram_cs_o    (dram_cs),
		.dram_we_o    (dram_we),
		.dram_ack_i   (dram_ack),
		.dram_data_i  (dram_rdata),
		.dram_data_o  (dram_wdata)
	);

	dram_model #(.PATTERN_KEY(PATTERN_KEY)) u_dram_model (
		.clk            (clk),
		.rst_n_i        (rst_n),
		.dram_addr_i    (dram_addr),
		.dram_cs_i      (dram_cs),
		.dram_we_i      (dram_we),
		.dram_data_i    (dram_wdata),
		.dram_ack_o     (dram_ack),
		.dram_data_o    (dram_rdata),
		.rd_count_o     (rd_count),
		.wr_count_o     (wr_count),
		.last_wr_addr_o (last_wr_addr),
		.last_wr_line_o (last_wr_line)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(negedge clk) begin
		if (!rst_n) begin
			ack_count <= 0;
		end else if (cache_ack) begin
			ack_count <= ack_count + 1;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// written words first, else the dram fill pattern
	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		logic [31:0] wa;
		wa = addr & ~32'h3;
		if (ref_mem.exists(wa)) begin
			return ref_mem[wa];
		end
		return wa ^ PATTERN_KEY;
	endfunction

	task automatic add_step(input logic we, input logic extra, input logic [31:0] addr,
			input logic [31:0] wdata, input int rd, input int wr, input logic [31:0] wb);
		steps.push_back('{we, extra, addr, wdata, rd, wr, wb});
	endtask

	task automatic strobe(input logic we, input logic [31:0] addr, input logic [31:0] data);
		cache_cs   = 1'b1;
		cache_we   = we;
		cache_addr = addr;
		cache_data = data;
		@(negedge clk);
		cache_cs = 1'b0;
	endtask

	task automatic wait_ack(output logic seen, output logic [31:0] data);
		seen = 1'b0;
		data = '0;
		for (int n = 0; n < TIMEOUT && !seen; n++) begin
			if (cache_ack) begin
				seen = 1'b1;
				data = cache_rdata;
			end else begin
				@(negedge clk);
			end
		end
	endtask

	task automatic run_step(input int i);
		step_t       s;
		logic        seen;
		logic [31:0] got;
		int          errors_before;
		s = steps[i];
		errors_before = errors;
		strobe(s.we, s.addr, s.wdata);
		// a second strobe while the miss is out at dram must be dropped
		if (s.extra) begin
			repeat (2) @(negedge clk);
			strobe(1'b1, s.addr, 32'hbad0_0bad);
		end
		wait_ack(seen, got);
		if (s.we) begin
			ref_mem[s.addr & ~32'h3] = s.wdata;
		end
		if (!seen) begin
			$display("step %0d: no acknowledge within %0d cycles", i, TIMEOUT);
			errors++;
		end else if (!s.we) begin
			check_value("cache_data_o", got, expected_word(s.addr));
		end
		check_value("rd_count", 32'(rd_count), 32'(s.exp_rd));
		check_value("wr_count", 32'(wr_count), 32'(s.exp_wr));
		if (s.wb_addr != '0) begin
			check_value("dram_addr_o", last_wr_addr, s.wb_addr);
			for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
				check_value("dram_data_o", last_wr_line[w*32 +: 32],
					expected_word(s.wb_addr + 32'(w * 4)));
			end
		end
		if (errors != errors_before) begin
			failed_steps++;
		end
		$display("step %0d %s %h: %s", i, s.we ? "write" : "read", s.addr,
			(errors == errors_before) ? "ok" : "failed");
	endtask

	initial begin
		rst_n      = 1'b0;
		cache_cs   = 1'b0;
		cache_we   = 1'b0;
		cache_addr = '0;
		cache_data = '0;
		errors       = 0;
		failed_steps = 0;
		// we     extra  addr           wdata          rd wr wb line
		add_step(1'b0, 1'b0, 32'h0000_1040, 32'h0,         1, 0, 32'h0);
		add_step(1'b0, 1'b0, 32'h0000_105c, 32'h0,         1, 0, 32'h0);
		add_step(1'b0, 1'b0, 32'h0000_1048, 32'h0,         1, 0, 32'h0);
		add_step(1'b1, 1'b0, 32'h0000_1044, 32'hdead_beef, 1, 0, 32'h0);
		add_step(1'b0, 1'b0, 32'h0000_1044, 32'h0,         1, 0, 32'h0);
		add_step(1'b0, 1'b1, 32'h0000_2044, 32'h0,         2, 1, 32'h0000_1040);
		add_step(1'b0, 1'b0, 32'h0000_1044, 32'h0,         3, 1, 32'h0);
		add_step(1'b0, 1'b0, 32'h0000_3080, 32'h0,         4, 1, 32'h0);
		add_step(1'b1, 1'b1, 32'h0000_5088, 32'h1234_5678, 5, 1, 32'h0);
		add_step(1'b0, 1'b0, 32'h0000_5088, 32'h0,         5, 1, 32'h0);
		add_step(1'b0, 1'b0, 32'h0000_5084, 32'h0,         5, 1, 32'h0);
		add_step(1'b0, 1'b0, 32'h0000_508c, 32'h0,         5, 1, 32'h0);
		add_step(1'b0, 1'b0, 32'h0000_3084, 32'h0,         6, 2, 32'h0000_5080);
		add_step(1'b0, 1'b0, 32'h0000_5088, 32'h0,         7, 2, 32'h0);
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		for (int i = 0; i < steps.size(); i++) begin
			run_step(i);
		end
		repeat (2) @(negedge clk);
		check_value("cache_ack_o count", 32'(ack_count), 32'(steps.size()));
		$display("steps %0d, failed %0d, errors %0d, acks %0d",
			steps.size(), failed_steps, errors, ack_count);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
